// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP      := lc4_core_tb
RTL_TOP  := lc4_core
FILELIST := list.f
BUILD    := obj_dir
LOG      := sim.log
SOURCES  := $(wildcard design/*.sv verification/*.sv verification/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Verification passed" $(LOG)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== design/lc4_core.sv ====
`default_nettype none

module lc4_core #(
    parameter lc4_pkg::word_t P_RESET_PC = 16'h8200
) (
    input  wire                         gwe,
    input  wire                         i_rst_n,
    input  wire lc4_pkg::word_t         i_cur_insn,
    output wire lc4_pkg::word_t         o_cur_pc,
    output wire lc4_pkg::word_t         o_wb_pc,
    output wire lc4_pkg::word_t         o_wb_insn,
    output wire                         o_wb_we,
    output wire lc4_pkg::reg_sel_t      o_wb_sel,
    output wire lc4_pkg::word_t         o_wb_data,
    output wire                         o_nzp_we,
    output wire lc4_pkg::nzp_t          o_nzp_bits,
    output wire lc4_pkg::stall_code_t   o_wb_stall
);
    import lc4_pkg::*;

    // fetch to decode
    wire word_t       f_insn;
    wire word_t       f_pc;
    wire stall_code_t f_stall;

    // register file read ports
    wire reg_sel_t    rd_sel_s;
    wire reg_sel_t    rd_sel_t;
    wire word_t       rd_data_s;
    wire word_t       rd_data_t;

    // decode to execute
    wire alu_op_t     x_op;
    wire reg_sel_t    x_dst;
    wire reg_sel_t    x_src_s;
    wire reg_sel_t    x_src_t;
    wire word_t       x_a;
    wire word_t       x_b;
    wire word_t       x_imm;
    wire nzp_t        x_nzp_mask;
    wire word_t       x_pc;
    wire word_t       x_insn;
    wire stall_code_t x_stall;

    wire              br_taken;
    wire word_t       br_target;

    lc4_fetch #(
        .P_RESET_PC (P_RESET_PC)
    ) fetch0 (
        .gwe         (gwe),
        .i_rst_n     (i_rst_n),
        .i_cur_insn  (i_cur_insn),
        .i_br_taken  (br_taken),
        .i_br_target (br_target),
        .o_cur_pc    (o_cur_pc),
        .o_f_insn    (f_insn),
        .o_f_pc      (f_pc),
        .o_f_stall   (f_stall)
    );

    lc4_decode decode0 (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .i_f_insn     (f_insn),
        .i_f_pc       (f_pc),
        .i_f_stall    (f_stall),
        .i_br_taken   (br_taken),
        .i_wb_we      (o_wb_we),
        .i_wb_sel     (o_wb_sel),
        .i_wb_data    (o_wb_data),
        .i_rd_data_s  (rd_data_s),
        .i_rd_data_t  (rd_data_t),
        .o_rd_sel_s   (rd_sel_s),
        .o_rd_sel_t   (rd_sel_t),
        .o_x_op       (x_op),
        .o_x_dst      (x_dst),
        .o_x_src_s    (x_src_s),
        .o_x_src_t    (x_src_t),
        .o_x_a        (x_a),
        .o_x_b        (x_b),
        .o_x_imm      (x_imm),
        .o_x_nzp_mask (x_nzp_mask),
        .o_x_pc       (x_pc),
        .o_x_insn     (x_insn),
        .o_x_stall    (x_stall)
    );

    // written from the writeback latch one edge after retirement
    lc4_regfile regfile0 (
        .gwe         (gwe),
        .i_rst_n     (i_rst_n),
        .i_rd_sel_s  (rd_sel_s),
        .i_rd_sel_t  (rd_sel_t),
        .i_wr_we     (o_wb_we),
        .i_wr_sel    (o_wb_sel),
        .i_wr_data   (o_wb_data),
        .o_rd_data_s (rd_data_s),
        .o_rd_data_t (rd_data_t)
    );

    lc4_execute execute0 (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .i_x_op       (x_op),
        .i_x_dst      (x_dst),
        .i_x_src_s    (x_src_s),
        .i_x_src_t    (x_src_t),
        .i_x_a        (x_a),
        .i_x_b        (x_b),
        .i_x_imm      (x_imm),
        .i_x_nzp_mask (x_nzp_mask),
        .i_x_pc       (x_pc),
        .i_x_insn     (x_insn),
        .i_x_stall    (x_stall),
        .o_br_taken   (br_taken),
        .o_br_target  (br_target),
        .o_wb_we      (o_wb_we),
        .o_wb_sel     (o_wb_sel),
        .o_wb_data    (o_wb_data),
        .o_wb_pc      (o_wb_pc),
        .o_wb_insn    (o_wb_insn),
        .o_nzp_we     (o_nzp_we),
        .o_nzp_bits   (o_nzp_bits),
        .o_wb_stall   (o_wb_stall)
    );

endmodule

`default_nettype wire

// ==== design/lc4_decode.sv ====
`default_nettype none

module lc4_decode (
    input  wire                         gwe,
    input  wire                         i_rst_n,
    input  wire lc4_pkg::word_t         i_f_insn,
    input  wire lc4_pkg::word_t         i_f_pc,
    input  wire lc4_pkg::stall_code_t   i_f_stall,
    input  wire                         i_br_taken,
    input  wire                         i_wb_we,
    input  wire lc4_pkg::reg_sel_t      i_wb_sel,
    input  wire lc4_pkg::word_t         i_wb_data,
    input  wire lc4_pkg::word_t         i_rd_data_s,
    input  wire lc4_pkg::word_t         i_rd_data_t,
    output lc4_pkg::reg_sel_t           o_rd_sel_s,
    output lc4_pkg::reg_sel_t           o_rd_sel_t,
    output lc4_pkg::alu_op_t            o_x_op,
    output lc4_pkg::reg_sel_t           o_x_dst,
    output lc4_pkg::reg_sel_t           o_x_src_s,
    output lc4_pkg::reg_sel_t           o_x_src_t,
    output lc4_pkg::word_t              o_x_a,
    output lc4_pkg::word_t              o_x_b,
    output lc4_pkg::word_t              o_x_imm,
    output lc4_pkg::nzp_t               o_x_nzp_mask,
    output lc4_pkg::word_t              o_x_pc,
    output lc4_pkg::word_t              o_x_insn,
    output lc4_pkg::stall_code_t        o_x_stall
);
    import lc4_pkg::*;

    opcode_t  opc;
    reg_sel_t dst;
    alu_op_t  dec_op;
    word_t    dec_imm;
    word_t    val_s;
    word_t    val_t;

    assign opc        = i_f_insn[F_OPC_HI:F_OPC_LO];
    assign dst        = i_f_insn[F_DST_HI:F_DST_LO];
    assign o_rd_sel_s = i_f_insn[F_SRC_S_HI:F_SRC_S_LO];
    assign o_rd_sel_t = i_f_insn[F_SRC_T_HI:F_SRC_T_LO];

    // write-through of the instruction retiring this cycle
    assign val_s = (i_wb_we && i_wb_sel == o_rd_sel_s) ? i_wb_data : i_rd_data_s;
    assign val_t = (i_wb_we && i_wb_sel == o_rd_sel_t) ? i_wb_data : i_rd_data_t;

    always_comb begin
        dec_op  = ALU_NOP;
        dec_imm = {{7{i_f_insn[F_IMM9_HI]}}, i_f_insn[F_IMM9_HI:0]};
        case (opc)
            OPC_ADD: begin
                if (i_f_insn[F_IMM_FLAG]) begin
                    dec_op  = ALU_ADDI;
                    dec_imm = {{11{i_f_insn[F_IMM5_HI]}}, i_f_insn[F_IMM5_HI:0]};
                end else if (i_f_insn[F_SUB_HI:F_SUB_LO] == 3'b000) begin
                    dec_op = ALU_ADD;
                end
            end
            OPC_AND: begin
                if (i_f_insn[F_SUB_HI:F_SUB_LO] == 3'b000) begin
                    dec_op = ALU_AND;
                end
            end
            OPC_CONST: dec_op = ALU_CONST;
            // mask 000 decodes as a branch that is never taken
            OPC_BR:    dec_op = ALU_BR;
            default:   dec_op = ALU_NOP;
        endcase
    end

    // decode to execute latch
    always_ff @(posedge gwe) begin
        if (!i_rst_n || i_br_taken) begin
            o_x_op    <= ALU_NOP;
            o_x_insn  <= '0;
            o_x_pc    <= '0;
            o_x_stall <= STALL_FLUSH;
        end else begin
            o_x_op    <= dec_op;
            o_x_insn  <= i_f_insn;
            o_x_pc    <= i_f_pc;
            o_x_stall <= i_f_stall;
        end
        o_x_dst      <= dst;
        o_x_src_s    <= o_rd_sel_s;
        o_x_src_t    <= o_rd_sel_t;
        o_x_a        <= val_s;
        o_x_b        <= val_t;
        o_x_imm      <= dec_imm;
        o_x_nzp_mask <= dst;
    end

endmodule

`default_nettype wire

// ==== design/lc4_execute.sv ====
`default_nettype none

module lc4_execute (
    input  wire                         gwe,
    input  wire                         i_rst_n,
    input  wire lc4_pkg::alu_op_t       i_x_op,
    input  wire lc4_pkg::reg_sel_t      i_x_dst,
    input  wire lc4_pkg::reg_sel_t      i_x_src_s,
    input  wire lc4_pkg::reg_sel_t      i_x_src_t,
    input  wire lc4_pkg::word_t         i_x_a,
    input  wire lc4_pkg::word_t         i_x_b,
    input  wire lc4_pkg::word_t         i_x_imm,
    input  wire lc4_pkg::nzp_t          i_x_nzp_mask,
    input  wire lc4_pkg::word_t         i_x_pc,
    input  wire lc4_pkg::word_t         i_x_insn,
    input  wire lc4_pkg::stall_code_t   i_x_stall,
    output logic                        o_br_taken,
    output lc4_pkg::word_t              o_br_target,
    output logic                        o_wb_we,
    output lc4_pkg::reg_sel_t           o_wb_sel,
    output lc4_pkg::word_t              o_wb_data,
    output lc4_pkg::word_t              o_wb_pc,
    output lc4_pkg::word_t              o_wb_insn,
    output logic                        o_nzp_we,
    output lc4_pkg::nzp_t               o_nzp_bits,
    output lc4_pkg::stall_code_t        o_wb_stall
);
    import lc4_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t result;
    logic  writes_reg;
    nzp_t  res_nzp;
    nzp_t  nzp_q;

    // writeback to execute bypass from the instruction one ahead
    assign op_a = (o_wb_we && o_wb_sel == i_x_src_s) ? o_wb_data : i_x_a;
    assign op_b = (o_wb_we && o_wb_sel == i_x_src_t) ? o_wb_data : i_x_b;

    always_comb begin
        case (i_x_op)
            ALU_ADD:   result = op_a + op_b;
            ALU_ADDI:  result = op_a + i_x_imm;
            ALU_AND:   result = op_a & op_b;
            ALU_CONST: result = i_x_imm;
            default:   result = '0;
        endcase
    end

    assign writes_reg = (i_x_op == ALU_ADD) || (i_x_op == ALU_ADDI) ||
                        (i_x_op == ALU_AND) || (i_x_op == ALU_CONST);

    // sign of the result taken as a signed word
    always_comb begin
        if ($signed(result) < 0) begin
            res_nzp = 3'b100;
        end else if (result == '0) begin
            res_nzp = 3'b010;
        end else begin
            res_nzp = 3'b001;
        end
    end

    // branch compares against the flags of the last retired writer
    assign o_br_taken  = (i_x_op == ALU_BR) && ((i_x_nzp_mask & nzp_q) != 3'b000);
    assign o_br_target = i_x_pc + 16'd1 + i_x_imm;

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            nzp_q <= 3'b000;
        end else if (writes_reg) begin
            nzp_q <= res_nzp;
        end
    end

    // writeback latch and retirement record
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            o_wb_we    <= 1'b0;
            o_nzp_we   <= 1'b0;
            o_wb_stall <= STALL_FLUSH;
            o_wb_insn  <= '0;
            o_wb_pc    <= '0;
            o_wb_sel   <= '0;
            o_wb_data  <= '0;
            o_nzp_bits <= '0;
        end else begin
            o_wb_we    <= writes_reg;
            o_nzp_we   <= writes_reg;
            o_wb_stall <= i_x_stall;
            o_wb_insn  <= i_x_insn;
            o_wb_pc    <= i_x_pc;
            o_wb_sel   <= i_x_dst;
            o_wb_data  <= result;
            o_nzp_bits <= writes_reg ? res_nzp : 3'b000;
        end
    end

endmodule

`default_nettype wire

// ==== design/lc4_fetch.sv ====
`default_nettype none

module lc4_fetch #(
    parameter lc4_pkg::word_t P_RESET_PC = 16'h8200
) (
    input  wire                         gwe,
    input  wire                         i_rst_n,
    input  wire lc4_pkg::word_t         i_cur_insn,
    input  wire                         i_br_taken,
    input  wire lc4_pkg::word_t         i_br_target,
    output lc4_pkg::word_t              o_cur_pc,
    output lc4_pkg::word_t              o_f_insn,
    output lc4_pkg::word_t              o_f_pc,
    output lc4_pkg::stall_code_t        o_f_stall
);
    import lc4_pkg::*;

    word_t pc_q;
    word_t pc_next;

    // a branch resolved in execute redirects the PC on the next edge
    assign pc_next  = i_br_taken ? i_br_target : pc_q + 16'd1;
    assign o_cur_pc = pc_q;

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            pc_q <= P_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // fetch to decode latch
    always_ff @(posedge gwe) begin
        if (!i_rst_n || i_br_taken) begin
            // squash the word fetched down the wrong path
            o_f_insn  <= '0;
            o_f_pc    <= '0;
            o_f_stall <= STALL_FLUSH;
        end else begin
            o_f_insn  <= i_cur_insn;
            o_f_pc    <= pc_q;
            o_f_stall <= STALL_NONE;
        end
    end

endmodule

`default_nettype wire

// ==== design/lc4_pkg.sv ====
`default_nettype none

package lc4_pkg;

    // data word, instruction word and PC share one width
    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_sel_t;
    // one-hot condition bits with n = 100, z = 010 and p = 001
    typedef logic [2:0]  nzp_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [1:0]  stall_code_t;

    localparam int unsigned REG_COUNT = 8;

    localparam opcode_t OPC_BR    = 4'b0000;
    localparam opcode_t OPC_ADD   = 4'b0001;
    localparam opcode_t OPC_AND   = 4'b0101;
    localparam opcode_t OPC_CONST = 4'b1001;

    // decoded operations carried from decode to execute
    localparam alu_op_t ALU_NOP   = 3'd0;
    localparam alu_op_t ALU_ADD   = 3'd1;
    localparam alu_op_t ALU_ADDI  = 3'd2;
    localparam alu_op_t ALU_AND   = 3'd3;
    localparam alu_op_t ALU_CONST = 3'd4;
    localparam alu_op_t ALU_BR    = 3'd5;

    // instruction field positions
    localparam int F_OPC_HI   = 15;
    localparam int F_OPC_LO   = 12;
    localparam int F_DST_HI   = 11;
    localparam int F_DST_LO   = 9;
    localparam int F_SRC_S_HI = 8;
    localparam int F_SRC_S_LO = 6;
    localparam int F_SUB_HI   = 5;
    localparam int F_SUB_LO   = 3;
    localparam int F_SRC_T_HI = 2;
    localparam int F_SRC_T_LO = 0;
    // bit 5 selects the immediate form of ADD
    localparam int F_IMM_FLAG = 5;
    localparam int F_IMM5_HI  = 4;
    localparam int F_IMM9_HI  = 8;

    // reset bubbles and flushed slots both retire as STALL_FLUSH
    localparam stall_code_t STALL_NONE  = 2'd0;
    localparam stall_code_t STALL_FLUSH = 2'd2;

endpackage

`default_nettype wire

// ==== design/lc4_regfile.sv ====
`default_nettype none

module lc4_regfile (
    input  wire                         gwe,
    input  wire                         i_rst_n,
    input  wire lc4_pkg::reg_sel_t      i_rd_sel_s,
    input  wire lc4_pkg::reg_sel_t      i_rd_sel_t,
    input  wire                         i_wr_we,
    input  wire lc4_pkg::reg_sel_t      i_wr_sel,
    input  wire lc4_pkg::word_t         i_wr_data,
    output lc4_pkg::word_t              o_rd_data_s,
    output lc4_pkg::word_t              o_rd_data_t
);
    import lc4_pkg::*;

    word_t regs [0:REG_COUNT-1];

    // combinational read ports
    // a same-cycle write is forwarded in decode
    assign o_rd_data_s = regs[i_rd_sel_s];
    assign o_rd_data_t = regs[i_rd_sel_t];

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_we) begin
            regs[i_wr_sel] <= i_wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verification
design/lc4_pkg.sv
design/lc4_fetch.sv
design/lc4_regfile.sv
design/lc4_decode.sv
design/lc4_execute.sv
design/lc4_core.sv
verification/lc4_core_tb.sv

// ==== verification/lc4_program.svh ====
`ifndef LC4_PROGRAM_SVH
`define LC4_PROGRAM_SVH

// program image with index 0 at the reset PC
word_t prog_mem [0:255];

// expected retirement records in order of the rising edges after reset
word_t       exp_pc    [$];
logic        exp_we    [$];
reg_sel_t    exp_sel   [$];
word_t       exp_data  [$];
nzp_t        exp_nzp   [$];
stall_code_t exp_stall [$];

task automatic add_retire(input word_t pc, input logic we, input reg_sel_t sel,
                          input word_t data, input nzp_t nzp, input stall_code_t stall);
    exp_pc.push_back(pc);
    exp_we.push_back(we);
    exp_sel.push_back(sel);
    exp_data.push_back(data);
    exp_nzp.push_back(nzp);
    exp_stall.push_back(stall);
endtask

task automatic load_tables;
    prog_mem = '{default: '0};
    // CONST r1 5, CONST r2 -3
    prog_mem[8'd0]  = 16'h9205;
    prog_mem[8'd1]  = 16'h95FD;
    // dependent chain r3..r1
    prog_mem[8'd2]  = 16'h1642;
    prog_mem[8'd3]  = 16'h18FE;
    prog_mem[8'd4]  = 16'h5A81;
    prog_mem[8'd5]  = 16'h1C82;
    prog_mem[8'd6]  = 16'h1F85;
    prog_mem[8'd7]  = 16'h53C4;
    // BRp +3 not taken, NOP, BRz +4 taken
    prog_mem[8'd8]  = 16'h0203;
    prog_mem[8'd9]  = 16'h0000;
    prog_mem[8'd10] = 16'h0404;
    // wrong-path words that must never write a register
    prog_mem[8'd11] = 16'h9401;
    prog_mem[8'd12] = 16'h9601;
    prog_mem[8'd13] = 16'h9807;
    prog_mem[8'd14] = 16'h9807;
    // branch target at 820F
    prog_mem[8'd15] = 16'h14A1;
    prog_mem[8'd16] = 16'h9700;
    prog_mem[8'd17] = 16'h18EF;
    // BRnp +2 taken on a negative result
    prog_mem[8'd18] = 16'h0A02;
    prog_mem[8'd19] = 16'h9BFF;
    prog_mem[8'd20] = 16'h9BFF;
    prog_mem[8'd21] = 16'h1D44;
    prog_mem[8'd22] = 16'h9E00;
    prog_mem[8'd23] = 16'h5186;

    // reset bubbles still draining out of decode and execute
    add_retire(16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_FLUSH);
    add_retire(16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_FLUSH);
    add_retire(16'h8200, 1'b1, 3'd1, 16'h0005, 3'b001, STALL_NONE);
    add_retire(16'h8201, 1'b1, 3'd2, 16'hFFFD, 3'b100, STALL_NONE);
    // r3 gets 5 plus -3 through bypass and write-through
    add_retire(16'h8202, 1'b1, 3'd3, 16'h0002, 3'b001, STALL_NONE);
    add_retire(16'h8203, 1'b1, 3'd4, 16'h0000, 3'b010, STALL_NONE);
    add_retire(16'h8204, 1'b1, 3'd5, 16'h0005, 3'b001, STALL_NONE);
    add_retire(16'h8205, 1'b1, 3'd6, 16'hFFFA, 3'b100, STALL_NONE);
    add_retire(16'h8206, 1'b1, 3'd7, 16'hFFFF, 3'b100, STALL_NONE);
    add_retire(16'h8207, 1'b1, 3'd1, 16'h0000, 3'b010, STALL_NONE);
    // not-taken branch and NOP retire without a flush
    add_retire(16'h8208, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_NONE);
    add_retire(16'h8209, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_NONE);
    add_retire(16'h820A, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_NONE);
    add_retire(16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_FLUSH);
    add_retire(16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_FLUSH);
    // r2 still holds -3 since the squashed CONST never retired
    add_retire(16'h820F, 1'b1, 3'd2, 16'hFFFE, 3'b100, STALL_NONE);
    add_retire(16'h8210, 1'b1, 3'd3, 16'hFF00, 3'b100, STALL_NONE);
    add_retire(16'h8211, 1'b1, 3'd4, 16'hFF0F, 3'b100, STALL_NONE);
    add_retire(16'h8212, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_NONE);
    add_retire(16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_FLUSH);
    add_retire(16'h0000, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_FLUSH);
    add_retire(16'h8215, 1'b1, 3'd6, 16'hFF14, 3'b100, STALL_NONE);
    add_retire(16'h8216, 1'b1, 3'd7, 16'h0000, 3'b010, STALL_NONE);
    add_retire(16'h8217, 1'b1, 3'd0, 16'hFF14, 3'b100, STALL_NONE);
    // first word past the program image reads back as a NOP
    add_retire(16'h8218, 1'b0, 3'd0, 16'h0000, 3'b000, STALL_NONE);
endtask

`endif

// ==== verification/lc4_core_tb.sv ====
`default_nettype none

module lc4_core_tb;
    import lc4_pkg::*;

    localparam word_t RESET_PC       = 16'h8200;
    localparam int    RESET_CYCLES   = 8;
    localparam int    RETIRE_TIMEOUT = 16;

    logic  gwe = 1'b0;
    logic  i_rst_n;
    word_t i_cur_insn = '0;

    wire word_t       o_cur_pc;
    wire word_t       o_wb_pc;
    wire word_t       o_wb_insn;
    wire              o_wb_we;
    wire reg_sel_t    o_wb_sel;
    wire word_t       o_wb_data;
    wire              o_nzp_we;
    wire nzp_t        o_nzp_bits;
    wire stall_code_t o_wb_stall;

    int error_count   = 0;
    int check_count   = 0;
    int timeout_count = 0;

    `include "lc4_program.svh"

    always #20 gwe = ~gwe;

    lc4_core #(
        .P_RESET_PC (RESET_PC)
    ) dut0 (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .i_cur_insn (i_cur_insn),
        .o_cur_pc   (o_cur_pc),
        .o_wb_pc    (o_wb_pc),
        .o_wb_insn  (o_wb_insn),
        .o_wb_we    (o_wb_we),
        .o_wb_sel   (o_wb_sel),
        .o_wb_data  (o_wb_data),
        .o_nzp_we   (o_nzp_we),
        .o_nzp_bits (o_nzp_bits),
        .o_wb_stall (o_wb_stall)
    );

    function automatic word_t fetch_word(input word_t pc);
        word_t offset;
        offset = pc - RESET_PC;
        if (offset[15:8] == 8'h00) begin
            return prog_mem[offset[7:0]];
        end
        return '0;
    endfunction

    // instruction memory answers the PC that settled on the rising edge
    always @(negedge gwe) begin
        i_cur_insn <= fetch_word(o_cur_pc);
    end

    task automatic check_value(input string what, input word_t actual, input word_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_reset_state;
        check_value("reset stall", word_t'(o_wb_stall), word_t'(STALL_FLUSH));
        check_value("reset wb_we", word_t'(o_wb_we), 16'h0000);
        check_value("reset nzp_we", word_t'(o_nzp_we), 16'h0000);
        check_value("reset cur_pc", o_cur_pc, RESET_PC);
    endtask

    task automatic wait_retirement(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < RETIRE_TIMEOUT) begin
            @(posedge gwe);
            @(negedge gwe);
            cycles++;
            seen = !$isunknown(o_wb_stall);
        end
    endtask

    task automatic check_retirement(input int row);
        string tag;
        tag = $sformatf("row %0d", row);
        check_value({tag, " stall"}, word_t'(o_wb_stall), word_t'(exp_stall[row]));
        check_value({tag, " wb_we"}, word_t'(o_wb_we), word_t'(exp_we[row]));
        check_value({tag, " nzp_we"}, word_t'(o_nzp_we), word_t'(exp_we[row]));
        if (exp_stall[row] == STALL_NONE) begin
            check_value({tag, " pc"}, o_wb_pc, exp_pc[row]);
            check_value({tag, " insn"}, o_wb_insn, fetch_word(exp_pc[row]));
        end else begin
            // squashed slots carry a zero instruction
            check_value({tag, " insn"}, o_wb_insn, 16'h0000);
        end
        if (exp_we[row]) begin
            check_value({tag, " sel"}, word_t'(o_wb_sel), word_t'(exp_sel[row]));
            check_value({tag, " data"}, o_wb_data, exp_data[row]);
            check_value({tag, " nzp"}, word_t'(o_nzp_bits), word_t'(exp_nzp[row]));
        end
    endtask

    initial begin
        bit seen;
        i_rst_n = 1'b0;
        load_tables();

        repeat (RESET_CYCLES) begin
            @(negedge gwe);
            check_reset_state();
        end
        i_rst_n = 1'b1;

        for (int row = 0; row < exp_pc.size() && timeout_count == 0; row++) begin
            wait_retirement(seen);
            if (seen) begin
                check_retirement(row);
            end else begin
                timeout_count++;
                $display("timeout at %0t: no retirement record for row %0d within %0d cycles",
                         $time, row, RETIRE_TIMEOUT);
            end
        end

        $display("checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
